/* vlog.f */
rtl/memPkg.sv
rtl/memBusIf.sv
rtl/memArbiter.sv
rtl/addrSequencer.sv
rtl/byteLane.sv
rtl/byteRam.sv
rtl/memCtrlTop.sv
testbench/clockGen.sv
testbench/memCtrlTb.sv

/* Bender.yml */
package:
  name: memctrl

sources:
  - files:
      - rtl/memPkg.sv
      - rtl/memBusIf.sv
      - rtl/memArbiter.sv
      - rtl/addrSequencer.sv
      - rtl/byteLane.sv
      - rtl/byteRam.sv
      - rtl/memCtrlTop.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/memCtrlTb.sv

/* testbench/memCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrlTb;
    import memPkg::*;

    typedef enum logic [1:0] {opStore, opLoad, opFetch, opBoth} op_t;

    typedef struct packed {
        op_t op;
        logic [ramAddrWidth-1:0] addr;
        accessLen_t len;
        logic [xLen-1:0] data;
        logic [3:0] stalls;
    } entry_t;

    localparam int numTests = 15;
    // fetch entries ignore len, opBoth loads and fetches the same address
    localparam entry_t tests [numTests] = '{
        '{opStore, 10'h010, lenWord, 32'hA1B2C3D4, 4'd0},
        '{opLoad,  10'h010, lenWord, 32'h00000000, 4'd0},
        '{opLoad,  10'h010, lenByte, 32'h00000000, 4'd1},
        '{opLoad,  10'h010, lenHalf, 32'h00000000, 4'd0},
        '{opStore, 10'h011, lenByte, 32'h00000055, 4'd2},
        '{opStore, 10'h012, lenHalf, 32'h00009966, 4'd0},
        '{opLoad,  10'h010, lenWord, 32'h00000000, 4'd3},
        '{opFetch, 10'h010, lenWord, 32'h00000000, 4'd0},
        '{opStore, 10'h020, lenWord, 32'h13579BDF, 4'd2},
        '{opBoth,  10'h020, lenWord, 32'h00000000, 4'd0},
        '{opStore, 10'h3F8, lenWord, 32'hCAFEF00D, 4'd5},
        '{opLoad,  10'h3FA, lenHalf, 32'h00000000, 4'd4},
        '{opFetch, 10'h3F8, lenWord, 32'h00000000, 4'd6},
        '{opBoth,  10'h010, lenHalf, 32'h00000000, 4'd8},
        '{opLoad,  10'h020, lenWord, 32'h00000000, 4'd7}
    };

    logic clk;
    logic rst;
    logic rdy;
    logic ioBufferFull;
    logic fetchEn;
    logic [ramAddrWidth-1:0] fetchAddr;
    logic dataEn;
    logic dataStore;
    accessLen_t dataLen;
    logic [ramAddrWidth-1:0] dataAddr;
    logic [xLen-1:0] dataWrData;
    logic fetchDone;
    logic [xLen-1:0] fetchInst;
    logic dataDone;
    logic [xLen-1:0] dataRdData;
    owner_t fetchWait;
    owner_t dataWait;

    logic [byteWidth-1:0] shadow [2**ramAddrWidth];
    integer seed;
    int stallsLeft;
    int cycles;
    int limit;

    clockGen clkGen (
        .clk(clk),
        .rst(rst)
    );

    memCtrlTop memCtrlTop_inst (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .ioBufferFull(ioBufferFull),
        .fetchEn(fetchEn),
        .fetchAddr(fetchAddr),
        .dataEn(dataEn),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWrData(dataWrData),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .dataDone(dataDone),
        .dataRdData(dataRdData),
        .fetchWait(fetchWait),
        .dataWait(dataWait)
    );

    function automatic int lenBytes(input accessLen_t len);
        case (len)
            lenByte: return 1;
            lenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic string opName(input op_t op);
        case (op)
            opStore: return "store";
            opLoad:  return "load";
            opFetch: return "fetch";
            default: return "fetch+load";
        endcase
    endfunction

    // little-endian, bytes past n stay zero
    function automatic logic [xLen-1:0] shadowWord(input logic [ramAddrWidth-1:0] addr,
                                                   input int n);
        logic [xLen-1:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = shadow[addr + i];
        end
        return w;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("Fail %s: expected %h, actual %h", what, expected, actual);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic stopWithError(input string msg);
        $display("Error: %s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    // freeze the next cycle at random while the entry still has stalls left
    task automatic driveStall();
        integer r;
        r = $random(seed);
        if (stallsLeft > 0 && r[0]) begin
            stallsLeft--;
            if (r[1]) begin
                rdy <= 1'b0;
                ioBufferFull <= 1'b0;
            end else begin
                rdy <= 1'b1;
                ioBufferFull <= 1'b1;
            end
        end else begin
            rdy <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    endtask

    task automatic runEntry(input int idx);
        entry_t e;
        string name;
        int n;
        int advCount;
        logic wantData;
        logic wantFetch;
        logic busy;
        logic busyData;
        logic advancing;
        logic [xLen-1:0] expData;
        logic [xLen-1:0] expInst;
        owner_t expOwner;
        e = tests[idx];
        name = $sformatf("entry %0d %s", idx, opName(e.op));
        n = lenBytes(e.len);
        expData = shadowWord(e.addr, n);
        expInst = shadowWord(e.addr, 4);
        wantData = (e.op != opFetch);
        wantFetch = (e.op == opFetch) || (e.op == opBoth);
        busy = 1'b0;
        busyData = 1'b0;
        advCount = 0;
        stallsLeft = e.stalls;
        @(posedge clk);
        dataEn <= wantData;
        dataStore <= (e.op == opStore);
        dataLen <= e.len;
        dataAddr <= e.addr;
        dataWrData <= e.data;
        fetchEn <= wantFetch;
        fetchAddr <= e.addr;
        driveStall();
        while (wantData || wantFetch) begin
            @(negedge clk);
            advancing = rdy && !ioBufferFull;
            if (!advancing) begin
                assert (!fetchDone && !dataDone)
                    else stopWithError({"done pulse during a frozen cycle in ", name});
            end
            expOwner = ownNone;
            if (busy && !fetchDone && !dataDone) begin
                expOwner = busyData ? ownData : ownFetch;
            end
            assert (fetchWait == expOwner)
                else reportMismatch({name, " fetchWait"}, expOwner, fetchWait);
            assert (dataWait == expOwner)
                else reportMismatch({name, " dataWait"}, expOwner, dataWait);
            if (busy && advancing) begin
                advCount++;
            end
            if (dataDone) begin
                assert (busy && busyData)
                    else stopWithError({"dataDone without a data access in ", name});
                if (e.op == opStore) begin
                    assert (advCount == n)
                        else reportMismatch({name, " store cycles"}, n, advCount);
                    for (int i = 0; i < n; i++) begin
                        shadow[e.addr + i] = e.data[8*i +: 8];
                    end
                end else begin
                    assert (advCount == n + 1)
                        else reportMismatch({name, " load cycles"}, n + 1, advCount);
                    assert (dataRdData == expData)
                        else reportMismatch({name, " dataRdData"}, expData, dataRdData);
                end
                wantData = 1'b0;
                busy = 1'b0;
            end else if (fetchDone) begin
                assert (busy && !busyData)
                    else stopWithError({"fetchDone without a fetch in ", name});
                assert (advCount == 5)
                    else reportMismatch({name, " fetch cycles"}, 5, advCount);
                assert (fetchInst == expInst)
                    else reportMismatch({name, " fetchInst"}, expInst, fetchInst);
                wantFetch = 1'b0;
                busy = 1'b0;
            end else if (!busy && advancing) begin
                // idle arbiter takes the request on this edge, data first
                busy = 1'b1;
                busyData = wantData;
                advCount = 0;
            end
            @(posedge clk);
            dataEn <= wantData;
            fetchEn <= wantFetch;
            driveStall();
        end
    endtask

    initial begin
        seed = 32'h49b5d6f3;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = lenByte;
        dataAddr = '0;
        dataWrData = '0;
        while (rst !== 1'b0) @(negedge clk);
        // quiet outputs before the first request
        repeat (3) begin
            @(negedge clk);
            assert (!fetchDone && !dataDone)
                else stopWithError("done pulse with no request after reset");
            assert (fetchWait == ownNone && dataWait == ownNone)
                else reportMismatch("after reset owners", 32'd0, {fetchWait, dataWait});
        end
        for (int i = 0; i < numTests; i++) begin
            runEntry(i);
        end
        $display("Everything OK");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        limit = 0;
        for (int i = 0; i < numTests; i++) begin
            limit += 6 + tests[i].stalls;
        end
        limit = 2 * limit;
        cycles = 0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                cycles++;
            end
            if (cycles > limit) begin
                $display("Timeout: the DUT never finished within %0d cycles", limit);
                $display("Something failed");
                $fatal(1);
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* rtl/memCtrlTop.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrlTop (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic ioBufferFull,
    input  logic fetchEn,
    input  logic [memPkg::ramAddrWidth-1:0] fetchAddr,
    input  logic dataEn,
    input  logic dataStore,
    input  memPkg::accessLen_t dataLen,
    input  logic [memPkg::ramAddrWidth-1:0] dataAddr,
    input  logic [memPkg::xLen-1:0] dataWrData,
    output logic fetchDone,
    output logic [memPkg::xLen-1:0] fetchInst,
    output logic dataDone,
    output logic [memPkg::xLen-1:0] dataRdData,
    output memPkg::owner_t fetchWait,
    output memPkg::owner_t dataWait
);
    import memPkg::*;

    logic capture;
    logic captureData;
    stage_t stage;
    logic collect;
    logic clearWord;
    logic writeEn;
    logic [byteWidth-1:0] writeByte;
    logic [xLen-1:0] word;
    logic [ramAddrWidth-1:0] curAddr;
    logic [ramAddrWidth-1:0] storeOffset;

    memBusIf ramBus ();

    memArbiter arbiter (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .ioBufferFull(ioBufferFull),
        .fetchEn(fetchEn),
        .dataEn(dataEn),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .capture(capture),
        .captureData(captureData),
        .stage(stage),
        .collect(collect),
        .clearWord(clearWord),
        .writeEn(writeEn),
        .fetchDone(fetchDone),
        .dataDone(dataDone),
        .fetchOwner(fetchWait),
        .dataOwner(dataWait)
    );

    addrSequencer addrSeq (
        .clk(clk),
        .rst(rst),
        .capture(capture),
        .captureData(captureData),
        .fetchAddr(fetchAddr),
        .dataAddr(dataAddr),
        .stage(stage),
        .bus(ramBus.ctrl),
        .curAddr(curAddr)
    );

    byteLane lane (
        .clk(clk),
        .rst(rst),
        .capture(capture),
        .captureData(captureData),
        .dataWrData(dataWrData),
        .stage(stage),
        .collect(collect),
        .clearWord(clearWord),
        .readByte(ramBus.readByte),
        .writeByte(writeByte),
        .word(word)
    );

    byteRam ram (
        .clk(clk),
        .bus(ramBus.ram)
    );

    assign ramBus.writeEn = writeEn;
    assign ramBus.writeByte = writeByte;

    // one assembly register serves both requesters
    assign fetchInst = word;
    assign dataRdData = word;

    assign storeOffset = curAddr - dataAddr;

    // writes stay inside the held store request
    writeInRange: assert property (@(posedge clk) disable iff (rst)
        writeEn |-> dataStore && (storeOffset < 4));

endmodule

`default_nettype wire

/* rtl/byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input logic clk,
    memBusIf.ram bus
);
    import memPkg::*;

    logic [byteWidth-1:0] mem [2**ramAddrWidth];

    always_ff @(posedge clk) begin
        if (bus.writeEn) begin
            mem[bus.addr] <= bus.writeByte;
        end
    end

    // registered read, old contents on a same-address write
    always_ff @(posedge clk) begin
        bus.readByte <= mem[bus.addr];
    end

endmodule

`default_nettype wire

/* rtl/byteLane.sv */
`timescale 1ns/1ps
`default_nettype none

module byteLane (
    input  logic clk,
    input  logic rst,
    input  logic capture,
    input  logic captureData,
    input  logic [memPkg::xLen-1:0] dataWrData,
    input  memPkg::stage_t stage,
    input  logic collect,
    input  logic clearWord,
    input  logic [memPkg::byteWidth-1:0] readByte,
    output logic [memPkg::byteWidth-1:0] writeByte,
    output logic [memPkg::xLen-1:0] word
);
    import memPkg::*;

    logic [xLen-1:0] storeData;
    logic [xLen-1:0] wordReg;
    logic [xLen-1:0] assembled;
    logic [1:0] collectLane;

    // byte read in stage s belongs to lane s-1
    assign collectLane = stage[1:0] - 2'd1;

    always_comb begin
        assembled = wordReg;
        if (collect) begin
            assembled[collectLane*byteWidth +: byteWidth] = readByte;
        end
    end

    // last byte is merged on the fly so done and word line up
    assign word = assembled;

    always_ff @(posedge clk) begin
        if (capture && captureData) begin
            storeData <= dataWrData;
        end
    end

    // uncollected lanes stay zero for zero-extension
    always_ff @(posedge clk) begin
        if (rst) begin
            wordReg <= '0;
        end else if (capture || clearWord) begin
            wordReg <= '0;
        end else if (collect) begin
            wordReg <= assembled;
        end
    end

    assign writeByte = storeData[stage[1:0]*byteWidth +: byteWidth];

endmodule

`default_nettype wire

/* rtl/addrSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module addrSequencer (
    input  logic clk,
    input  logic rst,
    input  logic capture,
    input  logic captureData,
    input  logic [memPkg::ramAddrWidth-1:0] fetchAddr,
    input  logic [memPkg::ramAddrWidth-1:0] dataAddr,
    input  memPkg::stage_t stage,
    memBusIf.ctrl bus,
    output logic [memPkg::ramAddrWidth-1:0] curAddr
);
    import memPkg::*;

    logic [ramAddrWidth-1:0] baseAddr;
    // one extra bit to catch a run past the last byte
    logic [ramAddrWidth:0] fullAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            baseAddr <= '0;
        end else if (capture) begin
            baseAddr <= captureData ? dataAddr : fetchAddr;
        end
    end

    assign fullAddr = {1'b0, baseAddr} + {{(ramAddrWidth - 2){1'b0}}, stage};
    assign curAddr = fullAddr[ramAddrWidth-1:0];
    assign bus.addr = curAddr;

    // accesses may not run past the last RAM byte
    noAddrWrap: assert property (@(posedge clk) disable iff (rst)
        (stage != 3'd0) |-> !fullAddr[ramAddrWidth]);

endmodule

`default_nettype wire

/* rtl/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic ioBufferFull,
    input  logic fetchEn,
    input  logic dataEn,
    input  logic dataStore,
    input  memPkg::accessLen_t dataLen,
    output logic capture,
    output logic captureData,
    output memPkg::stage_t stage,
    output logic collect,
    output logic clearWord,
    output logic writeEn,
    output logic fetchDone,
    output logic dataDone,
    output memPkg::owner_t fetchOwner,
    output memPkg::owner_t dataOwner
);
    import memPkg::*;

    arbState_t state;
    stage_t stageReg;
    accessLen_t len;
    stage_t endBytes;
    owner_t curOwner;
    logic advance;
    logic reading;
    logic readLast;
    logic writeLast;

    // the I/O buffer stall and the ready level freeze everything
    assign advance = rdy && !ioBufferFull;

    assign endBytes = bytesOf(len);
    assign reading = (state == stReadInst) || (state == stReadData);
    // a read collects its last byte one stage after the last address
    assign readLast = reading && (stageReg == endBytes);
    assign writeLast = (state == stWriteData) && (stageReg == endBytes - 3'd1);

    // frozen read repeats the previous address so the RAM output byte holds
    assign stage = (reading && !advance && (stageReg != 3'd0)) ? stageReg - 3'd1 : stageReg;

    // data side wins when both ask
    assign capture = advance && (state == stIdle) && (dataEn || fetchEn);
    assign captureData = dataEn;

    assign collect = advance && reading && (stageReg != 3'd0);
    assign clearWord = advance && readLast;
    assign writeEn = advance && (state == stWriteData);

    assign fetchDone = advance && readLast && (state == stReadInst);
    assign dataDone = advance && (((state == stReadData) && readLast) || writeLast);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            stageReg <= 3'd0;
            len <= lenByte;
        end else if (advance) begin
            case (state)
                stIdle: begin
                    stageReg <= 3'd0;
                    if (dataEn) begin
                        state <= dataStore ? stWriteData : stReadData;
                        len <= dataLen;
                    end else if (fetchEn) begin
                        state <= stReadInst;
                        len <= lenWord;
                    end
                end
                stReadInst, stReadData: begin
                    if (readLast) begin
                        state <= stIdle;
                        stageReg <= 3'd0;
                    end else begin
                        stageReg <= stageReg + 3'd1;
                    end
                end
                stWriteData: begin
                    if (writeLast) begin
                        state <= stIdle;
                        stageReg <= 3'd0;
                    end else begin
                        stageReg <= stageReg + 3'd1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // owner drops back to none in the done cycle
    always_comb begin
        curOwner = ownNone;
        if (!(fetchDone || dataDone)) begin
            case (state)
                stReadInst: curOwner = ownFetch;
                stReadData, stWriteData: curOwner = ownData;
                default: curOwner = ownNone;
            endcase
        end
    end

    assign fetchOwner = curOwner;
    assign dataOwner = curOwner;

    // requesters drop their enable right after done
    doneFetchOnce: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone);
    doneDataOnce: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone);

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone));

endmodule

`default_nettype wire

/* rtl/memBusIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface memBusIf;

    logic [memPkg::ramAddrWidth-1:0] addr;
    logic writeEn;
    logic [memPkg::byteWidth-1:0] writeByte;
    // reflects the address of the previous edge
    logic [memPkg::byteWidth-1:0] readByte;

    modport ctrl (
        output addr,
        output writeEn,
        output writeByte,
        input  readByte
    );

    modport ram (
        input  addr,
        input  writeEn,
        input  writeByte,
        output readByte
    );

endinterface

`default_nettype wire

/* rtl/memPkg.sv */
`default_nettype none

package memPkg;

    localparam int xLen = 32;
    localparam int byteWidth = 8;
    localparam int ramAddrWidth = 10;

    typedef enum logic [1:0] {
        lenByte = 2'b00,
        lenHalf = 2'b01,
        lenWord = 2'b10
    } accessLen_t;

    typedef enum logic [1:0] {
        stIdle      = 2'b00,
        stReadInst  = 2'b01,
        stReadData  = 2'b10,
        stWriteData = 2'b11
    } arbState_t;

    // data side reports 01, fetch side 10
    typedef enum logic [1:0] {
        ownNone  = 2'b00,
        ownData  = 2'b01,
        ownFetch = 2'b10
    } owner_t;

    // byte stages 0 to 4
    typedef logic [2:0] stage_t;

    function automatic stage_t bytesOf(input accessLen_t len);
        case (len)
            lenByte: return 3'd1;
            lenHalf: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

`default_nettype wire
